/* Makefile */
# Verilator flow for the SECDED word memory.

VERILATOR ?= verilator
TOP       ?= tb_ecc_mem_top
RTL_TOP   ?= ecc_mem_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard design/*.sv) $(wildcard testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/ecc_38_top.sv */
`timescale 1ns/1ps

module ecc_38_top (
    input  logic [ecc_pkg::data_width-1:0]   data_in,
    output logic [ecc_pkg::data_width-1:0]   data_out,
    input  logic [ecc_pkg::parity_width-1:0] parity_in,
    output logic [ecc_pkg::parity_width-1:0] parity_out,
    input  logic                             bypass,
    output logic                             sbit_err,
    output logic                             dbit_err
);

    logic [ecc_pkg::parity_width-1:0] syndrome;
    logic [ecc_pkg::data_width-1:0]   flip_mask;
    logic                             data_hit;
    logic                             check_hit;
    logic                             nonzero;

    // ====================================================================
    // encoder
    // ====================================================================
    // each check bit ends up as an XOR tree over the data bits whose
    // column has that row set.
    always_comb begin : encode
        parity_out = '0;
        for (int i = 0; i < ecc_pkg::data_width; i++) begin
            parity_out = parity_out ^ (ecc_pkg::h_cols[i] & {ecc_pkg::parity_width{data_in[i]}});
        end
    end

    assign syndrome = parity_in ^ parity_out;

    // ====================================================================
    // syndrome decode
    // ====================================================================
    always_comb begin : decode
        flip_mask = '0;
        data_hit  = 1'b0;
        for (int i = 0; i < ecc_pkg::data_width; i++) begin
            if (syndrome == ecc_pkg::h_cols[i]) begin
                flip_mask[i] = 1'b1; // single data bit in error.
                data_hit     = 1'b1;
            end
        end
    end

    assign check_hit = $onehot(syndrome); // a check bit flipped on its own.
    assign nonzero   = |syndrome;

    // bypass hands back the raw word and hides the flags.
    assign data_out = bypass ? data_in : (data_in ^ flip_mask);
    assign sbit_err = !bypass && (data_hit || check_hit);
    assign dbit_err = !bypass && nonzero && !data_hit && !check_hit;

endmodule

/* design/ecc_err_log.sv */
`timescale 1ns/1ps

module ecc_err_log (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           log_clear,
    input  logic                           rd_valid,
    input  ecc_pkg::rd_result_t            rd_result,
    output logic [ecc_pkg::cnt_width-1:0]  sbit_count,
    output logic [ecc_pkg::cnt_width-1:0]  dbit_count,
    output logic [ecc_pkg::addr_width-1:0] last_dbit_addr
);

    logic sbit_hit;
    logic dbit_hit;

    assign sbit_hit = rd_valid && rd_result.status.sbit_err;
    assign dbit_hit = rd_valid && rd_result.status.dbit_err;

    // ====================================================================
    // counters and last double error address
    // ====================================================================
    always_ff @(posedge clk) begin
        if (reset || log_clear) begin // clear wins over a same-cycle hit.
            sbit_count     <= '0;
            dbit_count     <= '0;
            last_dbit_addr <= '0;
        end else begin
            if (sbit_hit && (sbit_count != '1)) begin
                sbit_count <= sbit_count + 1'b1; // holds at all ones.
            end
            if (dbit_hit) begin
                if (dbit_count != '1) begin
                    dbit_count <= dbit_count + 1'b1;
                end
                last_dbit_addr <= rd_result.addr;
            end
        end
    end

    a_sbit_monotonic: assert property (
        @(posedge clk) disable iff (reset)
        !log_clear |=> sbit_count >= $past(sbit_count)
    );

    a_dbit_monotonic: assert property (
        @(posedge clk) disable iff (reset)
        !log_clear |=> dbit_count >= $past(dbit_count)
    );

endmodule

/* design/ecc_mem_top.sv */
`timescale 1ns/1ps

module ecc_mem_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wr_en,
    input  logic [ecc_pkg::addr_width-1:0] wr_addr,
    input  logic [ecc_pkg::data_width-1:0] wr_data,
    input  ecc_pkg::ecc_word_t             wr_flip,
    input  logic                           rd_en,
    input  logic [ecc_pkg::addr_width-1:0] rd_addr,
    input  logic                           bypass,
    input  logic                           log_clear,
    output logic                           rd_valid,
    output logic [ecc_pkg::data_width-1:0] rd_data,
    output ecc_pkg::ecc_status_t           rd_status,
    output logic [ecc_pkg::cnt_width-1:0]  sbit_count,
    output logic [ecc_pkg::cnt_width-1:0]  dbit_count,
    output logic [ecc_pkg::addr_width-1:0] last_dbit_addr
);

    logic [ecc_pkg::parity_width-1:0] enc_parity;
    ecc_pkg::ecc_word_t               wr_word;
    ecc_pkg::ecc_word_t               ram_word;
    logic [ecc_pkg::addr_width-1:0]   ram_word_addr;
    logic                             ram_word_valid;
    ecc_pkg::rd_result_t              rd_result;

    // ====================================================================
    // write side takes only the check bits from the encoder
    // ====================================================================
    ecc_38_top u_enc (
        .data_in    (wr_data),
        .data_out   (),
        .parity_in  ('0),
        .parity_out (enc_parity),
        .bypass     (1'b0),
        .sbit_err   (),
        .dbit_err   ()
    );

    assign wr_word.parity = enc_parity;
    assign wr_word.data   = wr_data;

    ecc_ram u_ram (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_word       (wr_word),
        .wr_flip       (wr_flip),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_word       (ram_word),
        .rd_word_addr  (ram_word_addr),
        .rd_word_valid (ram_word_valid)
    );

    // ====================================================================
    // read side
    // ====================================================================
    ecc_read_stage u_read (
        .clk        (clk),
        .reset      (reset),
        .word_in    (ram_word),
        .word_addr  (ram_word_addr),
        .word_valid (ram_word_valid),
        .bypass     (bypass),
        .rd_valid   (rd_valid),
        .rd_result  (rd_result)
    );

    assign rd_data   = rd_result.data;
    assign rd_status = rd_result.status;

    ecc_err_log u_log (
        .clk            (clk),
        .reset          (reset),
        .log_clear      (log_clear),
        .rd_valid       (rd_valid),
        .rd_result      (rd_result),
        .sbit_count     (sbit_count),
        .dbit_count     (dbit_count),
        .last_dbit_addr (last_dbit_addr)
    );

endmodule

/* design/ecc_pkg.sv */
package ecc_pkg;

    // ====================================================================
    // word geometry
    // ====================================================================
    localparam int data_width   = 38;                       // data bits per word.
    localparam int parity_width = 7;                        // check bits per word.
    localparam int code_width   = data_width + parity_width; // 45 stored bits.
    localparam int mem_depth    = 64;
    localparam int addr_width   = $clog2(mem_depth);
    localparam int cnt_width    = 16;                       // error log counters.

    // stored codeword with the check bits on top.
    typedef struct packed {
        logic [parity_width-1:0] parity;
        logic [data_width-1:0]   data;
    } ecc_word_t;

    typedef struct packed {
        logic sbit_err;
        logic dbit_err;
    } ecc_status_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        ecc_status_t           status;
        logic [addr_width-1:0] addr;
    } rd_result_t;

    // ====================================================================
    // SECDED check matrix with one odd-weight column per data bit
    // ====================================================================
    // listed from data bit 37 down to data bit 0.
    localparam logic [data_width-1:0][parity_width-1:0] h_cols = {
        7'b0101100, // d[37].
        7'b1101011,
        7'b0101010,
        7'b0101001,
        7'b1101000,
        7'b1100111, // d[32].
        7'b0100110,
        7'b0100101,
        7'b1100100,
        7'b0100011,
        7'b1100010,
        7'b1100001, // d[26].
        7'b0011111,
        7'b1011110,
        7'b1011101,
        7'b0011100,
        7'b1011011,
        7'b0011010,
        7'b0011001,
        7'b1011000, // d[18].
        7'b1010111,
        7'b0010110,
        7'b0010101,
        7'b1010100,
        7'b0010011,
        7'b1010010,
        7'b1010001, // d[11].
        7'b1001111,
        7'b0001110,
        7'b0001101,
        7'b1001100,
        7'b0001011,
        7'b1001010,
        7'b1001001, // d[4].
        7'b0000111,
        7'b1000110,
        7'b1000101,
        7'b1000011  // d[0].
    };

endpackage

/* design/ecc_ram.sv */
`timescale 1ns/1ps

module ecc_ram (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wr_en,
    input  logic [ecc_pkg::addr_width-1:0] wr_addr,
    input  ecc_pkg::ecc_word_t             wr_word,
    input  ecc_pkg::ecc_word_t             wr_flip,
    input  logic                           rd_en,
    input  logic [ecc_pkg::addr_width-1:0] rd_addr,
    output ecc_pkg::ecc_word_t             rd_word,
    output logic [ecc_pkg::addr_width-1:0] rd_word_addr,
    output logic                           rd_word_valid
);

    logic [ecc_pkg::code_width-1:0] mem [ecc_pkg::mem_depth];

    // ====================================================================
    // array access
    // ====================================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word ^ wr_flip; // flip mask only set by test.
        end
    end

    // same-edge write lands after this read, so the old word comes out.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word      <= mem[rd_addr];
            rd_word_addr <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_word_valid <= 1'b0;
        end else begin
            rd_word_valid <= rd_en;
        end
    end

    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_addr)
    );

    a_rd_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        rd_en |-> !$isunknown(rd_addr)
    );

endmodule

/* design/ecc_read_stage.sv */
`timescale 1ns/1ps

module ecc_read_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  ecc_pkg::ecc_word_t             word_in,
    input  logic [ecc_pkg::addr_width-1:0] word_addr,
    input  logic                           word_valid,
    input  logic                           bypass,
    output logic                           rd_valid,
    output ecc_pkg::rd_result_t            rd_result
);

    logic [ecc_pkg::data_width-1:0] chk_data;
    logic                           chk_sbit;
    logic                           chk_dbit;

    // recompute parity on the stored word and correct.
    ecc_38_top u_chk (
        .data_in    (word_in.data),
        .data_out   (chk_data),
        .parity_in  (word_in.parity),
        .parity_out (),
        .bypass     (bypass),
        .sbit_err   (chk_sbit),
        .dbit_err   (chk_dbit)
    );

    // ====================================================================
    // result register
    // ====================================================================
    always_ff @(posedge clk) begin
        if (word_valid) begin
            rd_result.data            <= chk_data;
            rd_result.status.sbit_err <= chk_sbit;
            rd_result.status.dbit_err <= chk_dbit;
            rd_result.addr            <= word_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= word_valid; // one cycle behind the ram output.
        end
    end

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        rd_valid |-> !(rd_result.status.sbit_err && rd_result.status.dbit_err)
    );

endmodule

/* list.f */
design/ecc_pkg.sv
design/ecc_38_top.sv
design/ecc_ram.sv
design/ecc_read_stage.sv
design/ecc_err_log.sv
design/ecc_mem_top.sv
testbench/tb_ecc_mem_top.sv

/* testbench/tb_ecc_mem_top.sv */
`timescale 1ns/1ps

module tb_ecc_mem_top;

    localparam int test_cycles    = 600;                    // rough length of all tests.
    localparam int timeout_cycles = 3 * test_cycles + 200;

    typedef struct packed {
        logic [ecc_pkg::data_width-1:0] data;
        ecc_pkg::ecc_status_t           status;
        logic                           check_data;   // data is undefined on a double error.
        logic [ecc_pkg::addr_width-1:0] addr;
    } exp_rec_t;

    logic                           clk;
    logic                           reset;
    logic                           wr_en;
    logic [ecc_pkg::addr_width-1:0] wr_addr;
    logic [ecc_pkg::data_width-1:0] wr_data;
    ecc_pkg::ecc_word_t             wr_flip;
    logic                           rd_en;
    logic [ecc_pkg::addr_width-1:0] rd_addr;
    logic                           bypass;
    logic                           log_clear;
    logic                           rd_valid;
    logic [ecc_pkg::data_width-1:0] rd_data;
    ecc_pkg::ecc_status_t           rd_status;
    logic [ecc_pkg::cnt_width-1:0]  sbit_count;
    logic [ecc_pkg::cnt_width-1:0]  dbit_count;
    logic [ecc_pkg::addr_width-1:0] last_dbit_addr;

    logic [ecc_pkg::data_width-1:0] model_data [ecc_pkg::mem_depth];
    ecc_pkg::ecc_word_t             model_flip [ecc_pkg::mem_depth];
    exp_rec_t                       exp_q [$];
    exp_rec_t                       cur_exp;
    logic                           cur_valid;
    logic [ecc_pkg::cnt_width-1:0]  model_sbit;
    logic [ecc_pkg::cnt_width-1:0]  model_dbit;
    logic [ecc_pkg::addr_width-1:0] model_last;
    logic                           rd_en_d1;
    logic                           rd_en_d2;
    int                             errors;
    int                             reads_checked;
    int                             cycle_count;

    ecc_mem_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================================================================
    // expected values
    // ====================================================================
    function automatic exp_rec_t expect_read(input logic [ecc_pkg::addr_width-1:0] a,
                                             input logic byp);
        exp_rec_t r;
        int       weight;
        weight       = $countones(model_flip[a]);
        r.addr       = a;
        r.data       = model_data[a];
        r.status     = '0;
        r.check_data = 1'b1;
        if (byp) begin
            r.data = model_data[a] ^ model_flip[a].data; // raw stored data.
        end else if (weight == 1) begin
            r.status.sbit_err = 1'b1;
        end else if (weight == 2) begin
            r.status.dbit_err = 1'b1;
            r.check_data      = 1'b0;
        end
        return r;
    endfunction

    always @(negedge clk) begin
        cur_valid = 1'b0;
        if (!reset && rd_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("rd_valid high at %0t with no read outstanding", $time);
            end else begin
                cur_exp   = exp_q.pop_front();
                cur_valid = 1'b1;
                reads_checked++;
            end
        end
    end

    // log tallies follow the flags of each checked read.
    always @(posedge clk) begin
        rd_en_d1 <= rd_en;
        rd_en_d2 <= rd_en_d1;
        if (reset || log_clear) begin
            model_sbit <= '0;
            model_dbit <= '0;
            model_last <= '0;
        end else if (cur_valid) begin
            if (cur_exp.status.sbit_err && (model_sbit != '1)) begin
                model_sbit <= model_sbit + 1'b1;
            end
            if (cur_exp.status.dbit_err) begin
                if (model_dbit != '1) begin
                    model_dbit <= model_dbit + 1'b1;
                end
                model_last <= cur_exp.addr;
            end
        end
    end

    // ====================================================================
    // checks
    // ====================================================================
    a_rd_latency: assert property (@(posedge clk) disable iff (reset) rd_valid == rd_en_d2)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t rd_valid expected %b actual %b",
                     $time, $sampled(rd_en_d2), $sampled(rd_valid));
        end

    a_rd_data: assert property (@(posedge clk) disable iff (reset)
        cur_valid && cur_exp.check_data |-> rd_data == cur_exp.data)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t rd_data expected %h actual %h",
                     $time, cur_exp.data, $sampled(rd_data));
        end

    a_rd_status: assert property (@(posedge clk) disable iff (reset)
        cur_valid |-> rd_status == cur_exp.status)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t rd_status expected %b actual %b",
                     $time, cur_exp.status, $sampled(rd_status));
        end

    a_sbit_count: assert property (@(posedge clk) disable iff (reset) sbit_count == model_sbit)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t sbit_count expected %0d actual %0d",
                     $time, $sampled(model_sbit), $sampled(sbit_count));
        end

    a_dbit_count: assert property (@(posedge clk) disable iff (reset) dbit_count == model_dbit)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t dbit_count expected %0d actual %0d",
                     $time, $sampled(model_dbit), $sampled(dbit_count));
        end

    a_last_addr: assert property (@(posedge clk) disable iff (reset)
        last_dbit_addr == model_last)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t last_dbit_addr expected %0d actual %0d",
                     $time, $sampled(model_last), $sampled(last_dbit_addr));
        end

    // ====================================================================
    // stimulus
    // ====================================================================
    task automatic step(input logic wr, input logic [ecc_pkg::addr_width-1:0] wa,
                        input logic [ecc_pkg::data_width-1:0] wd, input ecc_pkg::ecc_word_t wf,
                        input logic rd, input logic [ecc_pkg::addr_width-1:0] ra,
                        input logic byp, input logic clr);
        @(negedge clk);
        wr_en     = wr;
        wr_addr   = wa;
        wr_data   = wd;
        wr_flip   = wf;
        rd_en     = rd;
        rd_addr   = ra;
        bypass    = byp;
        log_clear = clr;
        if (rd) begin
            exp_q.push_back(expect_read(ra, byp)); // taken before the write lands.
        end
        if (wr) begin
            model_data[wa] = wd;
            model_flip[wa] = wf;
        end
    endtask

    task automatic idle();
        step(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic write_word(input logic [ecc_pkg::addr_width-1:0] a,
                              input ecc_pkg::ecc_word_t f);
        step(1'b1, a, random_data(), f, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic read_word(input logic [ecc_pkg::addr_width-1:0] a, input logic byp);
        step(1'b0, '0, '0, '0, 1'b1, a, byp, 1'b0);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            idle();
        end
        idle();
        idle();
    endtask

    function automatic logic [ecc_pkg::data_width-1:0] random_data();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[ecc_pkg::data_width-1:0];
    endfunction

    function automatic ecc_pkg::ecc_word_t flip_bits(input int p0, input int p1);
        logic [ecc_pkg::code_width-1:0] v;
        v = '0;
        v[p0] = 1'b1;
        if (p1 >= 0) begin
            v[p1] = 1'b1;
        end
        return ecc_pkg::ecc_word_t'(v);
    endfunction

    initial begin
        int p0;
        int p1;
        void'($urandom(32'h1ebb_f152));
        {wr_en, wr_addr, wr_data, wr_flip} = '0;
        {rd_en, rd_addr, bypass, log_clear} = '0;
        {cur_valid, rd_en_d1, rd_en_d2} = '0;
        errors        = 0;
        reads_checked = 0;
        reset         = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // clean round trip with the reads back to back.
        for (int k = 0; k < ecc_pkg::mem_depth; k++) begin
            write_word(k[5:0], '0);
        end
        for (int k = 0; k < ecc_pkg::mem_depth; k++) begin
            read_word(k[5:0], 1'b0);
        end
        drain();

        // single flips anywhere in the codeword followed by double flips.
        for (int k = 0; k < 24; k++) begin
            write_word(k[5:0], flip_bits($urandom_range(44, 0), -1));
        end
        for (int k = 48; k < 56; k++) begin
            p0 = $urandom_range(44, 0);
            p1 = $urandom_range(43, 0);
            if (p1 >= p0) begin
                p1++;
            end
            write_word(k[5:0], flip_bits(p0, p1));
        end
        for (int k = 0; k < 24; k++) begin
            read_word(k[5:0], 1'b0);
        end
        for (int k = 48; k < 56; k++) begin
            read_word(k[5:0], 1'b0);
        end
        drain();

        // bypass is sampled one edge after the read is taken.
        write_word(6'd60, flip_bits($urandom_range(37, 0), -1));
        drain();
        read_word(6'd60, 1'b1);
        step(1'b0, '0, '0, '0, 1'b0, '0, 1'b1, 1'b0);
        drain();

        // clear lands on the same edge as a flagged result.
        read_word(6'd3, 1'b0);
        idle();
        step(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b1);
        drain();
        read_word(6'd50, 1'b0);
        read_word(6'd7, 1'b0);
        drain();

        // write and read of one address in the same cycle.
        step(1'b1, 6'd5, random_data(), '0, 1'b1, 6'd5, 1'b0, 1'b0);
        read_word(6'd5, 1'b0);
        drain();

        $display("summary: %0d reads checked, %0d errors", reads_checked, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
